// File: action_crossbar.sv
`default_nettype none

module action_crossbar #(
    parameter int N_CONT = 4,
    localparam int IDX_W = $clog2(N_CONT)
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    input  wire logic [action_pkg::phv_w(N_CONT)-1:0]         phv_i,
    input  wire logic                                         phv_valid_i,
    input  wire logic [action_pkg::action_w(N_CONT, IDX_W)-1:0] action_i,
    input  wire logic                                         action_valid_i,
    output action_pkg::cont32_t                               wide_op_a_o   [N_CONT],
    output action_pkg::cont32_t                               wide_op_b_o   [N_CONT],
    output action_pkg::alu_op_e                               wide_op_o     [N_CONT],
    output action_pkg::cont16_t                               narrow_op_a_o [N_CONT],
    output action_pkg::cont16_t                               narrow_op_b_o [N_CONT],
    output action_pkg::alu_op_e                               narrow_op_o   [N_CONT],
    output action_pkg::meta_t                                 meta_o,
    output action_pkg::md_op_e                                md_op_o,
    output logic [action_pkg::MD_PORT_W-1:0]                  md_port_o,
    output logic                                              valid_o
);

    localparam int CA_W         = action_pkg::cont_act_w(IDX_W);
    localparam int NAR_LSB      = action_pkg::META_W;
    localparam int WIDE_LSB     = NAR_LSB + N_CONT * action_pkg::CONT_W_NARROW;
    localparam int NAR_ACT_LSB  = action_pkg::MD_ACT_W;
    localparam int WIDE_ACT_LSB = NAR_ACT_LSB + N_CONT * CA_W;
    localparam int SRC_A_LSB    = action_pkg::ACT_SRC_B_LSB + IDX_W;
    localparam int OP_LSB       = SRC_A_LSB + IDX_W;

    logic                act_en;
    action_pkg::cont32_t wide_c      [N_CONT];
    action_pkg::cont16_t narrow_c    [N_CONT];
    action_pkg::cont32_t wide_a_d    [N_CONT];
    action_pkg::cont32_t wide_b_d    [N_CONT];
    action_pkg::alu_op_e wide_op_d   [N_CONT];
    action_pkg::cont16_t narrow_a_d  [N_CONT];
    action_pkg::cont16_t narrow_b_d  [N_CONT];
    action_pkg::alu_op_e narrow_op_d [N_CONT];
    action_pkg::md_op_e  md_op_d;

    assign act_en = phv_valid_i && action_valid_i;

    for (genvar i = 0; i < N_CONT; i++) begin : g_sel
        logic [CA_W-1:0]     w_act;
        logic [CA_W-1:0]     n_act;
        action_pkg::alu_op_e w_op;
        action_pkg::alu_op_e n_op;
        logic                w_keep;
        logic                n_keep;

        assign wide_c[i]   = phv_i[WIDE_LSB + i * action_pkg::CONT_W_WIDE +:
                                   action_pkg::CONT_W_WIDE];
        assign narrow_c[i] = phv_i[NAR_LSB + i * action_pkg::CONT_W_NARROW +:
                                   action_pkg::CONT_W_NARROW];
        assign w_act = action_i[WIDE_ACT_LSB + i * CA_W +: CA_W];
        assign n_act = action_i[NAR_ACT_LSB + i * CA_W +: CA_W];
        assign w_op  = action_pkg::alu_op_e'(w_act[OP_LSB +: action_pkg::ALU_OP_W]);
        assign n_op  = action_pkg::alu_op_e'(n_act[OP_LSB +: action_pkg::ALU_OP_W]);

        // nop, unknown code or no action turns into a copy of the container itself
        assign w_keep = act_en && (w_op inside {action_pkg::OP_ADD, action_pkg::OP_SUB,
            action_pkg::OP_AND, action_pkg::OP_OR, action_pkg::OP_COPY, action_pkg::OP_SET});
        assign n_keep = act_en && (n_op inside {action_pkg::OP_ADD, action_pkg::OP_SUB,
            action_pkg::OP_AND, action_pkg::OP_OR, action_pkg::OP_COPY, action_pkg::OP_SET});

        assign wide_op_d[i] = w_keep ? w_op : action_pkg::OP_COPY;
        assign wide_a_d[i]  = w_keep ? wide_c[w_act[SRC_A_LSB +: IDX_W]] : wide_c[i];
        // immediate is zero-extended on wide containers
        assign wide_b_d[i]  = w_act[action_pkg::ACT_IMM_SEL_BIT]
                            ? action_pkg::cont32_t'(w_act[action_pkg::IMM_W-1:0])
                            : wide_c[w_act[action_pkg::ACT_SRC_B_LSB +: IDX_W]];

        assign narrow_op_d[i] = n_keep ? n_op : action_pkg::OP_COPY;
        assign narrow_a_d[i]  = n_keep ? narrow_c[n_act[SRC_A_LSB +: IDX_W]] : narrow_c[i];
        assign narrow_b_d[i]  = n_act[action_pkg::ACT_IMM_SEL_BIT]
                              ? action_pkg::cont16_t'(n_act[action_pkg::IMM_W-1:0])
                              : narrow_c[n_act[action_pkg::ACT_SRC_B_LSB +: IDX_W]];
    end

    assign md_op_d = act_en
                   ? action_pkg::md_op_e'(action_i[action_pkg::MD_OP_LSB +: action_pkg::MD_OP_W])
                   : action_pkg::MD_NOP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CONT; i++) begin
                wide_op_a_o[i]   <= '0;
                wide_op_b_o[i]   <= '0;
                wide_op_o[i]     <= action_pkg::OP_COPY;
                narrow_op_a_o[i] <= '0;
                narrow_op_b_o[i] <= '0;
                narrow_op_o[i]   <= action_pkg::OP_COPY;
            end
            meta_o    <= '0;
            md_op_o   <= action_pkg::MD_NOP;
            md_port_o <= '0;
            valid_o   <= 1'b0;
        end else begin
            for (int i = 0; i < N_CONT; i++) begin
                wide_op_a_o[i]   <= wide_a_d[i];
                wide_op_b_o[i]   <= wide_b_d[i];
                wide_op_o[i]     <= wide_op_d[i];
                narrow_op_a_o[i] <= narrow_a_d[i];
                narrow_op_b_o[i] <= narrow_b_d[i];
                narrow_op_o[i]   <= narrow_op_d[i];
            end
            meta_o    <= phv_i[action_pkg::META_W-1:0];
            md_op_o   <= md_op_d;
            md_port_o <= action_i[0 +: action_pkg::MD_PORT_W];
            valid_o   <= phv_valid_i;
        end
    end

    // a metadata action only ever travels with a stage valid
    a_md_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (md_op_o != action_pkg::MD_NOP) |-> valid_o);

endmodule

`default_nettype wire

// File: action_engine.sv
`default_nettype none

module action_engine #(
    parameter int N_CONT = 4,
    localparam int IDX_W = $clog2(N_CONT)
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    input  wire logic [action_pkg::phv_w(N_CONT)-1:0]         phv_i,
    input  wire logic                                         phv_valid_i,
    input  wire logic [action_pkg::action_w(N_CONT, IDX_W)-1:0] action_i,
    input  wire logic                                         action_valid_i,
    output logic [action_pkg::phv_w(N_CONT)-1:0]              phv_o,
    output logic                                              phv_valid_o
);

    // crossbar to alus
    action_pkg::cont32_t wide_op_a   [N_CONT];
    action_pkg::cont32_t wide_op_b   [N_CONT];
    action_pkg::alu_op_e wide_op     [N_CONT];
    action_pkg::cont16_t narrow_op_a [N_CONT];
    action_pkg::cont16_t narrow_op_b [N_CONT];
    action_pkg::alu_op_e narrow_op   [N_CONT];
    action_pkg::meta_t   xb_meta;
    action_pkg::md_op_e  xb_md_op;
    logic [action_pkg::MD_PORT_W-1:0] xb_md_port;
    logic                xb_valid;

    // alus to assembler
    action_pkg::cont32_t wide_res   [N_CONT];
    action_pkg::cont16_t narrow_res [N_CONT];
    action_pkg::meta_t   md_res;
    logic                md_valid;

    action_crossbar #(
        .N_CONT(N_CONT)
    ) u_crossbar (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_i          (phv_i),
        .phv_valid_i    (phv_valid_i),
        .action_i       (action_i),
        .action_valid_i (action_valid_i),
        .wide_op_a_o    (wide_op_a),
        .wide_op_b_o    (wide_op_b),
        .wide_op_o      (wide_op),
        .narrow_op_a_o  (narrow_op_a),
        .narrow_op_b_o  (narrow_op_b),
        .narrow_op_o    (narrow_op),
        .meta_o         (xb_meta),
        .md_op_o        (xb_md_op),
        .md_port_o      (xb_md_port),
        .valid_o        (xb_valid)
    );

    for (genvar i = 0; i < N_CONT; i++) begin : g_wide_alu
        container_alu #(
            .DATA_WIDTH(action_pkg::CONT_W_WIDE)
        ) u_alu (
            .clk         (clk),
            .rst_n       (rst_n),
            .op_i        (wide_op[i]),
            .operand_a_i (wide_op_a[i]),
            .operand_b_i (wide_op_b[i]),
            .result_o    (wide_res[i])
        );
    end

    for (genvar i = 0; i < N_CONT; i++) begin : g_narrow_alu
        container_alu #(
            .DATA_WIDTH(action_pkg::CONT_W_NARROW)
        ) u_alu (
            .clk         (clk),
            .rst_n       (rst_n),
            .op_i        (narrow_op[i]),
            .operand_a_i (narrow_op_a[i]),
            .operand_b_i (narrow_op_b[i]),
            .result_o    (narrow_res[i])
        );
    end

    metadata_alu u_md_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .meta_i    (xb_meta),
        .md_op_i   (xb_md_op),
        .md_port_i (xb_md_port),
        .valid_i   (xb_valid),
        .meta_o    (md_res),
        .valid_o   (md_valid)
    );

    phv_assembler #(
        .N_CONT(N_CONT)
    ) u_assembler (
        .clk          (clk),
        .rst_n        (rst_n),
        .wide_res_i   (wide_res),
        .narrow_res_i (narrow_res),
        .meta_i       (md_res),
        .valid_i      (md_valid),
        .phv_o        (phv_o),
        .phv_valid_o  (phv_valid_o)
    );

endmodule

`default_nettype wire

// File: action_pkg.sv
`default_nettype none

package action_pkg;

    // container and metadata widths
    localparam int CONT_W_WIDE   = 32;
    localparam int CONT_W_NARROW = 16;
    localparam int META_W        = 32;
    localparam int IMM_W         = 16;

    typedef logic [CONT_W_WIDE-1:0]   cont32_t;
    typedef logic [CONT_W_NARROW-1:0] cont16_t;
    typedef logic [META_W-1:0]        meta_t;

    localparam int ALU_OP_W  = 3;
    localparam int MD_OP_W   = 2;
    localparam int MD_PORT_W = 8;

    typedef enum logic [ALU_OP_W-1:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_COPY = 3'd5,
        OP_SET  = 3'd6
    } alu_op_e;

    typedef enum logic [MD_OP_W-1:0] {
        MD_NOP      = 2'd0,
        MD_SET_PORT = 2'd1,
        MD_DROP     = 2'd2,
        MD_FORWARD  = 2'd3
    } md_op_e;

    // container action, msb first: opcode, src a, src b, imm select, immediate
    localparam int ACT_IMM_SEL_BIT = IMM_W;
    localparam int ACT_SRC_B_LSB   = IMM_W + 1;

    function automatic int cont_act_w(input int idx_w);
        return ALU_OP_W + 2 * idx_w + 1 + IMM_W;
    endfunction

    // metadata action: op above the port
    localparam int MD_ACT_W  = MD_OP_W + MD_PORT_W;
    localparam int MD_OP_LSB = MD_PORT_W;

    // fields inside the metadata word
    localparam int META_PORT_LSB = 0;
    localparam int META_DROP_BIT = 8;

    // flat widths of the phv and of the action bundle
    function automatic int phv_w(input int n_cont);
        return n_cont * (CONT_W_WIDE + CONT_W_NARROW) + META_W;
    endfunction

    function automatic int action_w(input int n_cont, input int idx_w);
        return 2 * n_cont * cont_act_w(idx_w) + MD_ACT_W;
    endfunction

endpackage

`default_nettype wire

// File: container_alu.sv
`default_nettype none

module container_alu #(
    parameter int DATA_WIDTH = action_pkg::CONT_W_WIDE
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire action_pkg::alu_op_e   op_i,
    input  wire logic [DATA_WIDTH-1:0] operand_a_i,
    input  wire logic [DATA_WIDTH-1:0] operand_b_i,
    output logic [DATA_WIDTH-1:0]      result_o
);

    logic [DATA_WIDTH-1:0] result_d;

    // add and sub wrap at the container width
    always_comb begin
        case (op_i)
            action_pkg::OP_ADD: begin
                result_d = operand_a_i + operand_b_i;
            end
            action_pkg::OP_SUB: begin
                result_d = operand_a_i - operand_b_i;
            end
            action_pkg::OP_AND: begin
                result_d = operand_a_i & operand_b_i;
            end
            action_pkg::OP_OR: begin
                result_d = operand_a_i | operand_b_i;
            end
            action_pkg::OP_SET: begin
                result_d = operand_b_i;
            end
            // copy, and anything the crossbar should have filtered
            default: begin
                result_d = operand_a_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_o <= '0;
        end else begin
            result_o <= result_d;
        end
    end

    // crossbar rewrites every nop into a copy before it gets here
    a_no_nop: assert property (@(posedge clk) disable iff (!rst_n)
        op_i != action_pkg::OP_NOP);

endmodule

`default_nettype wire

// File: filelist.f
action_pkg.sv
action_crossbar.sv
container_alu.sv
metadata_alu.sv
phv_assembler.sv
action_engine.sv
tb_action_engine.sv

// File: metadata_alu.sv
`default_nettype none

module metadata_alu (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire action_pkg::meta_t              meta_i,
    input  wire action_pkg::md_op_e             md_op_i,
    input  wire logic [action_pkg::MD_PORT_W-1:0] md_port_i,
    input  wire logic                           valid_i,
    output action_pkg::meta_t                   meta_o,
    output logic                                valid_o
);

    action_pkg::meta_t meta_d;

    // only the port field and the drop bit ever change
    always_comb begin
        meta_d = meta_i;
        case (md_op_i)
            action_pkg::MD_SET_PORT: begin
                meta_d[action_pkg::META_PORT_LSB +: action_pkg::MD_PORT_W] = md_port_i;
            end
            action_pkg::MD_DROP: begin
                meta_d[action_pkg::META_DROP_BIT] = 1'b1;
            end
            action_pkg::MD_FORWARD: begin
                meta_d[action_pkg::META_PORT_LSB +: action_pkg::MD_PORT_W] = md_port_i;
                meta_d[action_pkg::META_DROP_BIT] = 1'b0;
            end
            // nop keeps the word as is
            default: begin
                meta_d = meta_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta_o  <= '0;
            valid_o <= 1'b0;
        end else begin
            meta_o  <= meta_d;
            valid_o <= valid_i;
        end
    end

endmodule

`default_nettype wire

// File: phv_assembler.sv
`default_nettype none

module phv_assembler #(
    parameter int N_CONT = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire action_pkg::cont32_t          wide_res_i   [N_CONT],
    input  wire action_pkg::cont16_t          narrow_res_i [N_CONT],
    input  wire action_pkg::meta_t            meta_i,
    input  wire logic                         valid_i,
    output logic [action_pkg::phv_w(N_CONT)-1:0] phv_o,
    output logic                              phv_valid_o
);

    localparam int PHV_W    = action_pkg::phv_w(N_CONT);
    localparam int NAR_LSB  = action_pkg::META_W;
    localparam int WIDE_LSB = NAR_LSB + N_CONT * action_pkg::CONT_W_NARROW;

    logic [PHV_W-1:0] phv_d;
    logic             keep;

    // dropped packets never reach the output
    assign keep = valid_i && !meta_i[action_pkg::META_DROP_BIT];

    // same layout as the input phv, wide on top and metadata at the bottom
    always_comb begin
        phv_d = '0;
        phv_d[action_pkg::META_W-1:0] = meta_i;
        for (int i = 0; i < N_CONT; i++) begin
            phv_d[WIDE_LSB + i * action_pkg::CONT_W_WIDE +: action_pkg::CONT_W_WIDE] = wide_res_i[i];
            phv_d[NAR_LSB + i * action_pkg::CONT_W_NARROW +: action_pkg::CONT_W_NARROW] =
                narrow_res_i[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phv_o       <= '0;
            phv_valid_o <= 1'b0;
        end else begin
            phv_valid_o <= keep;
            if (keep) begin
                phv_o <= phv_d;
            end
        end
    end

    a_no_drop_out: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_o |-> !phv_o[action_pkg::META_DROP_BIT]);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the action engine testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_action_engine \
    -f filelist.f -o sim_action_engine \
    && ./obj_dir/sim_action_engine > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation did not pass"; exit 1; }

// File: tb_action_engine.sv
`default_nettype none

module tb_action_engine;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CONT = 4;
    localparam int IDX_W  = $clog2(N_CONT);
    localparam int PHV_W  = action_pkg::phv_w(N_CONT);
    localparam int ACT_W  = action_pkg::action_w(N_CONT, IDX_W);
    localparam int W32    = action_pkg::CONT_W_WIDE;
    localparam int W16    = action_pkg::CONT_W_NARROW;

    // container action: op, src a, src b, imm select, immediate
    localparam int CA_W         = 3 + 2 * IDX_W + 1 + action_pkg::IMM_W;
    localparam int SRC_B_LSB    = action_pkg::IMM_W + 1;
    localparam int SRC_A_LSB    = SRC_B_LSB + IDX_W;
    localparam int OP_LSB       = SRC_A_LSB + IDX_W;
    localparam int NAR_LSB      = action_pkg::META_W;
    localparam int WIDE_LSB     = NAR_LSB + N_CONT * W16;
    localparam int NAR_ACT_LSB  = action_pkg::MD_ACT_W;
    localparam int WIDE_ACT_LSB = NAR_ACT_LSB + N_CONT * CA_W;
    localparam int DROP         = action_pkg::META_DROP_BIT;

    // run length, used for the timeout
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 40;
    localparam int N_RANDOM        = 300;
    localparam int MAX_GAP         = 2;
    localparam int DRAIN_CYCLES    = 16;
    localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES
                                   + N_RANDOM * (1 + MAX_GAP) + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES  = 10 * STIM_CYCLES;

    logic             clk;
    logic             rst_n;
    logic [PHV_W-1:0] phv_in;
    logic             phv_valid_in;
    logic [ACT_W-1:0] action_in;
    logic             action_valid_in;
    logic [PHV_W-1:0] phv_out;
    logic             phv_valid_out;

    logic [PHV_W-1:0] exp_q [$];
    int               due_q [$];
    int               cycle;
    logic [PHV_W-1:0] phv_buf;
    logic [ACT_W-1:0] act_buf;

    action_engine #(
        .N_CONT(N_CONT)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_i          (phv_in),
        .phv_valid_i    (phv_valid_in),
        .action_i       (action_in),
        .action_valid_i (action_valid_in),
        .phv_o          (phv_out),
        .phv_valid_o    (phv_valid_out)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    task automatic check_cont32(input string what, input action_pkg::cont32_t got,
                                input action_pkg::cont32_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_cont16(input string what, input action_pkg::cont16_t got,
                                input action_pkg::cont16_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_meta(input string what, input action_pkg::meta_t got,
                              input action_pkg::meta_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // container result from the opcode rules, narrow callers keep the low half
    function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] own);
        case (op)
            action_pkg::OP_ADD:  return a + b;
            action_pkg::OP_SUB:  return a - b;
            action_pkg::OP_AND:  return a & b;
            action_pkg::OP_OR:   return a | b;
            action_pkg::OP_COPY: return a;
            action_pkg::OP_SET:  return b;
            default:             return own;
        endcase
    endfunction

    function automatic logic [PHV_W-1:0] ref_action(input logic [PHV_W-1:0] phv,
                                                    input logic [ACT_W-1:0] act,
                                                    input logic act_valid, output logic drop);
        action_pkg::cont32_t w_in [N_CONT];
        action_pkg::cont16_t n_in [N_CONT];
        action_pkg::meta_t   meta;
        logic [PHV_W-1:0]    res;
        logic [CA_W-1:0]     ca;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         r;
        for (int i = 0; i < N_CONT; i++) begin
            w_in[i] = phv[WIDE_LSB + i * W32 +: W32];
            n_in[i] = phv[NAR_LSB + i * W16 +: W16];
        end
        meta = phv[action_pkg::META_W-1:0];
        res  = phv;
        if (act_valid) begin
            for (int i = 0; i < N_CONT; i++) begin
                ca = act[WIDE_ACT_LSB + i * CA_W +: CA_W];
                a  = w_in[ca[SRC_A_LSB +: IDX_W]];
                b  = ca[action_pkg::IMM_W] ? {16'b0, ca[15:0]} : w_in[ca[SRC_B_LSB +: IDX_W]];
                res[WIDE_LSB + i * W32 +: W32] = alu_ref(ca[OP_LSB +: 3], a, b, w_in[i]);
                ca = act[NAR_ACT_LSB + i * CA_W +: CA_W];
                a  = {16'b0, n_in[ca[SRC_A_LSB +: IDX_W]]};
                b  = {16'b0, ca[action_pkg::IMM_W] ? ca[15:0] : n_in[ca[SRC_B_LSB +: IDX_W]]};
                r  = alu_ref(ca[OP_LSB +: 3], a, b, {16'b0, n_in[i]});
                res[NAR_LSB + i * W16 +: W16] = r[15:0];
            end
            case (act[action_pkg::MD_ACT_W-1 -: 2])
                action_pkg::MD_SET_PORT: begin
                    meta[7:0] = act[7:0];
                end
                action_pkg::MD_DROP: begin
                    meta[DROP] = 1'b1;
                end
                action_pkg::MD_FORWARD: begin
                    meta[7:0]  = act[7:0];
                    meta[DROP] = 1'b0;
                end
                default: begin
                    meta = meta;
                end
            endcase
        end
        res[action_pkg::META_W-1:0] = meta;
        drop = meta[DROP];
        return res;
    endfunction

    // one PHV on the falling edge, expected result queued unless dropped
    task automatic send(input logic [PHV_W-1:0] phv, input logic [ACT_W-1:0] act,
                        input logic act_valid);
        logic             drop;
        logic [PHV_W-1:0] exp_phv;
        @(negedge clk);
        phv_in          = phv;
        action_in       = act;
        action_valid_in = act_valid;
        phv_valid_in    = 1'b1;
        exp_phv = ref_action(phv, act, act_valid, drop);
        if (!drop) begin
            exp_q.push_back(exp_phv);
            due_q.push_back(cycle + 3);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            phv_valid_in    = 1'b0;
            action_valid_in = 1'b0;
        end
    endtask

    task automatic set_cont_act(input bit wide, input int idx, input action_pkg::alu_op_e op,
                                input int src_a, input int src_b, input bit imm_sel,
                                input logic [action_pkg::IMM_W-1:0] imm);
        logic [CA_W-1:0] ca;
        ca = {op, src_a[IDX_W-1:0], src_b[IDX_W-1:0], imm_sel, imm};
        if (wide) begin
            act_buf[WIDE_ACT_LSB + idx * CA_W +: CA_W] = ca;
        end else begin
            act_buf[NAR_ACT_LSB + idx * CA_W +: CA_W] = ca;
        end
    endtask

    task automatic randomize_phv();
        for (int b = 0; b < PHV_W; b++) begin
            phv_buf[b] = 1'($urandom_range(0, 1));
        end
        // mostly live packets
        if ($urandom_range(0, 3) != 0) begin
            phv_buf[DROP] = 1'b0;
        end
    endtask

    task automatic randomize_action();
        for (int b = 0; b < ACT_W; b++) begin
            act_buf[b] = 1'($urandom_range(0, 1));
        end
        for (int i = 0; i < N_CONT; i++) begin
            act_buf[WIDE_ACT_LSB + i * CA_W + OP_LSB +: 3] = 3'($urandom_range(0, 6));
            act_buf[NAR_ACT_LSB + i * CA_W + OP_LSB +: 3]  = 3'($urandom_range(0, 6));
        end
    endtask

    task automatic load_edge_values();
        phv_buf = '0;
        phv_buf[WIDE_LSB + 0 * W32 +: W32] = 32'hFFFF_FFF0;
        phv_buf[WIDE_LSB + 1 * W32 +: W32] = 32'h0000_0020;
        phv_buf[WIDE_LSB + 2 * W32 +: W32] = 32'h8000_0001;
        phv_buf[WIDE_LSB + 3 * W32 +: W32] = 32'h1234_5678;
        phv_buf[NAR_LSB + 0 * W16 +: W16]  = 16'hFFF8;
        phv_buf[NAR_LSB + 1 * W16 +: W16]  = 16'h0010;
        phv_buf[NAR_LSB + 2 * W16 +: W16]  = 16'h8001;
        phv_buf[NAR_LSB + 3 * W16 +: W16]  = 16'h1234;
        phv_buf[action_pkg::META_W-1:0]    = 32'h00AB_CC12;
    endtask

    // compare on the falling edge, where outputs are stable
    always @(negedge clk) begin
        if (rst_n && phv_valid_out) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output: the DUT sent a PHV that no input accounts for");
                stop_with_failure();
            end else begin
                compare_phv(exp_q.pop_front(), due_q.pop_front());
            end
        end
    end

    task automatic compare_phv(input logic [PHV_W-1:0] exp_phv, input int due);
        if (cycle != due) begin
            $display("Error at %0t ns: output in cycle %0d, expected in cycle %0d",
                     $time, cycle, due);
            stop_with_failure();
        end
        for (int i = 0; i < N_CONT; i++) begin
            check_cont32($sformatf("wide container %0d", i),
                         phv_out[WIDE_LSB + i * W32 +: W32], exp_phv[WIDE_LSB + i * W32 +: W32]);
            check_cont16($sformatf("narrow container %0d", i),
                         phv_out[NAR_LSB + i * W16 +: W16], exp_phv[NAR_LSB + i * W16 +: W16]);
        end
        check_meta("metadata", phv_out[action_pkg::META_W-1:0],
                   exp_phv[action_pkg::META_W-1:0]);
    endtask

    initial begin
        int drain;
        void'($urandom(47));
        clk             = 1'b0;
        rst_n           = 1'b0;
        phv_in          = '0;
        phv_valid_in    = 1'b0;
        action_in       = '0;
        action_valid_in = 1'b0;
        cycle           = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        if (phv_valid_out !== 1'b0 || phv_out !== '0) begin
            $display("Reset failure: outputs were not cleared during reset");
            stop_with_failure();
        end
        rst_n = 1'b1;

        // pass-through with the action marked invalid
        for (int n = 0; n < 4; n++) begin
            randomize_phv();
            phv_buf[DROP] = 1'b0;
            randomize_action();
            send(phv_buf, act_buf, 1'b0);
        end
        idle(2);

        // every opcode on both widths, register then immediate operand
        for (int op = 1; op <= 6; op++) begin
            for (int sel = 0; sel < 2; sel++) begin
                load_edge_values();
                act_buf = '0;
                for (int i = 0; i < N_CONT; i++) begin
                    set_cont_act(1'b1, i, action_pkg::alu_op_e'(op[2:0]), i, (i + 1) % N_CONT,
                                 sel[0], 16'hFF20);
                    set_cont_act(1'b0, i, action_pkg::alu_op_e'(op[2:0]), i, (i + 1) % N_CONT,
                                 sel[0], 16'hFF20);
                end
                send(phv_buf, act_buf, 1'b1);
            end
        end
        idle(2);

        // operands taken from other containers of the same width
        randomize_phv();
        phv_buf[DROP] = 1'b0;
        act_buf = '0;
        for (int i = 0; i < N_CONT; i++) begin
            set_cont_act(1'b1, i, action_pkg::OP_ADD, (i + 1) % N_CONT, (i + 2) % N_CONT,
                         1'b0, '0);
            set_cont_act(1'b0, i, action_pkg::OP_COPY, N_CONT - 1 - i, i, 1'b0, '0);
        end
        send(phv_buf, act_buf, 1'b1);
        for (int i = 0; i < N_CONT; i++) begin
            set_cont_act(1'b1, i, action_pkg::OP_SUB, N_CONT - 1 - i, i, 1'b0, '0);
            set_cont_act(1'b0, i, action_pkg::OP_OR, (i + 1) % N_CONT, (i + 3) % N_CONT,
                         1'b0, '0);
        end
        set_cont_act(1'b1, 0, action_pkg::OP_NOP, 3, 2, 1'b0, '0);
        send(phv_buf, act_buf, 1'b1);
        idle(2);

        // metadata ops, the dropped one sits between live packets
        load_edge_values();
        act_buf = '0;
        act_buf[action_pkg::MD_ACT_W-1:0] = {action_pkg::MD_SET_PORT, 8'h5A};
        send(phv_buf, act_buf, 1'b1);
        phv_buf[DROP] = 1'b1;
        act_buf[action_pkg::MD_ACT_W-1:0] = {action_pkg::MD_FORWARD, 8'hC3};
        send(phv_buf, act_buf, 1'b1);
        phv_buf[DROP] = 1'b0;
        act_buf[action_pkg::MD_ACT_W-1:0] = {action_pkg::MD_NOP, 8'hEE};
        send(phv_buf, act_buf, 1'b1);
        act_buf[action_pkg::MD_ACT_W-1:0] = {action_pkg::MD_DROP, 8'h01};
        send(phv_buf, act_buf, 1'b1);
        act_buf[action_pkg::MD_ACT_W-1:0] = {action_pkg::MD_SET_PORT, 8'h11};
        send(phv_buf, act_buf, 1'b1);
        idle(2);

        // random stream with idle gaps
        for (int n = 0; n < N_RANDOM; n++) begin
            randomize_phv();
            randomize_action();
            send(phv_buf, act_buf, $urandom_range(0, 7) != 0);
            if ($urandom_range(0, 3) == 0) begin
                idle($urandom_range(1, MAX_GAP));
            end
        end
        idle(1);

        drain = 0;
        while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("Missing output: %0d expected PHVs never came out", exp_q.size());
            stop_with_failure();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
